// File: verification/pi_route_stimulus.txt
// id lv la0 la1 rv ra0 ra1 u0v u0a0 u0a1 u1v u1a0 u1a1 out_bp | exp out_v in_bp l_sel r_sel u0_sel u1_sel
// Byte fields hold {l, r, u0, u1} two bits each, l in bits 7:6; v fields hold one bit per channel
01 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 0 0 0 0
02 2 0 6 0 0 0 0 0 0 0 0 0 00 20 00 0 5 0 0
03 1 1 0 0 0 0 0 0 0 0 0 0 00 04 00 0 0 2 0
04 0 0 0 1 4 0 0 0 0 0 0 0 00 40 00 4 0 0 0
05 0 0 0 2 0 9 0 0 0 0 0 0 00 02 00 0 0 0 1
06 0 0 0 0 0 0 2 0 2 0 0 0 00 20 00 0 3 0 0
07 0 0 0 0 0 0 0 0 0 2 0 0 00 80 00 1 0 0 0
08 0 0 0 0 0 0 1 8 0 0 0 0 00 40 00 2 0 0 0
09 0 0 0 1 5 0 1 0 0 0 0 0 00 00 14 0 0 0 0
0a 0 0 0 1 5 0 1 0 0 0 0 0 00 40 04 4 0 0 0
0b 0 0 0 1 5 0 1 0 0 0 0 0 00 40 10 2 0 0 0
0c 3 6 6 0 0 0 0 0 0 0 0 0 00 10 80 0 4 0 0
0d 3 7 7 0 0 0 0 0 0 0 0 0 10 20 40 0 5 0 0
0e 2 0 c 2 0 3 0 0 0 0 0 0 00 0a 00 0 0 3 1
0f 3 f f 0 0 0 0 0 0 0 0 0 04 08 40 0 0 3 0
10 1 6 0 0 0 0 2 0 2 1 3 0 00 10 09 0 4 0 0
11 1 6 0 0 0 0 2 0 2 1 3 0 00 20 41 0 3 0 0
12 1 6 0 0 0 0 2 0 2 1 3 0 00 10 48 0 0 0 0
13 0 0 0 0 0 0 0 0 0 0 0 0 00 00 00 0 0 0 0

// File: files.f
rtl/pi_cfg_pkg.sv
rtl/pi_route_pkg.sv
rtl/pi_addr_decode.sv
rtl/pi_turn_arbiter.sv
rtl/pi_vc_grant.sv
rtl/pi_sel_encode.sv
rtl/pi_route_top.sv
verification/pi_route_tb.sv

// File: Bender.yml
package:
  name: pi_route

sources:
  - rtl/pi_cfg_pkg.sv
  - rtl/pi_route_pkg.sv
  - rtl/pi_addr_decode.sv
  - rtl/pi_turn_arbiter.sv
  - rtl/pi_vc_grant.sv
  - rtl/pi_sel_encode.sv
  - rtl/pi_route_top.sv
  - target: test
    files:
      - verification/pi_route_tb.sv

// File: verification/pi_route_tb.sv
// Run from the project root so the stimulus path resolves; switch is built with POSL=1, POSX=1
`timescale 1ns/10ps

module pi_route_tb;
    import pi_route_pkg::*;

    localparam int FIELDS  = 20; // Hex words per vector line
    localparam int MAX_VEC = 64; // Room in the vector memory
    localparam int POSL    = 1;  // Side bit is address bit 1
    localparam int POSX    = 1;  // Home subtree when address bits 3:2 equal 1

    logic     clk;
    logic     rst;
    port_in_t i_port;
    dir_vec_t i_out_bp;
    dir_vec_t o_out_v;
    dir_vec_t o_in_bp;
    sel_t     o_sel;

    // Flat image of the stimulus file with FIELDS words per vector
    logic [7:0] stim_mem [0:FIELDS*MAX_VEC-1];

    int n_vec;        // Vectors found in the file
    int cycle_limit;  // Zero until the file is loaded
    int cycle_cnt;
    int n_pass;
    int n_fail;
    int vec_errs;     // Mismatches in the vector being checked

    pi_route_top #(
        .POSL (POSL),
        .POSX (POSX)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .i_port   (i_port),
        .i_out_bp (i_out_bp),
        .o_out_v  (o_out_v),
        .o_in_bp  (o_in_bp),
        .o_sel    (o_sel)
    );

    always #5 clk = ~clk; // 10 ns period

    // Run guard whose limit follows the vector count
    always @(posedge clk) begin
        cycle_cnt++;
        if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // One hex word of a vector
    function automatic logic [7:0] field_at(input int vec, input int f);
        return stim_mem[vec*FIELDS + f];
    endfunction

    // Port heads and downstream back-pressure of one vector
    task automatic drive_vector(input int vec);
        i_port.l.v        = vc_vec_t'(field_at(vec, 1));
        i_port.l.addr[0]  = addr_t'(field_at(vec, 2));
        i_port.l.addr[1]  = addr_t'(field_at(vec, 3));
        i_port.r.v        = vc_vec_t'(field_at(vec, 4));
        i_port.r.addr[0]  = addr_t'(field_at(vec, 5));
        i_port.r.addr[1]  = addr_t'(field_at(vec, 6));
        i_port.u0.v       = vc_vec_t'(field_at(vec, 7));
        i_port.u0.addr[0] = addr_t'(field_at(vec, 8));
        i_port.u0.addr[1] = addr_t'(field_at(vec, 9));
        i_port.u1.v       = vc_vec_t'(field_at(vec, 10));
        i_port.u1.addr[0] = addr_t'(field_at(vec, 11));
        i_port.u1.addr[1] = addr_t'(field_at(vec, 12));
        i_out_bp          = dir_vec_t'(field_at(vec, 13)); // {l, r, u0, u1}
    endtask

    // One output field against its expected byte
    task automatic compare_output(
        input string      test,
        input string      sig,
        input logic [7:0] exp,
        input logic [7:0] act
    );
        assert (act === exp) else begin
            $display("ERROR %s %s expected 0x%02h actual 0x%02h", test, sig, exp, act);
            vec_errs++;
        end
    endtask

    task automatic check_vector(input int vec);
        string test;
        test     = $sformatf("vec_%02h", field_at(vec, 0));
        vec_errs = 0;
        compare_output(test, "o_out_v", field_at(vec, 14), o_out_v);
        compare_output(test, "o_in_bp", field_at(vec, 15), o_in_bp);
        compare_output(test, "l_sel",   field_at(vec, 16), 8'(o_sel.l_sel));
        compare_output(test, "r_sel",   field_at(vec, 17), 8'(o_sel.r_sel));
        compare_output(test, "u0_sel",  field_at(vec, 18), 8'(o_sel.u0_sel));
        compare_output(test, "u1_sel",  field_at(vec, 19), 8'(o_sel.u1_sel));
        if (vec_errs == 0) begin
            n_pass++;
            $display("PASS %s", test);
        end else begin
            n_fail++;
            $display("FAIL %s with %0d mismatches", test, vec_errs);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        i_port      = '0;
        i_out_bp    = '0;
        n_vec       = 0;
        cycle_limit = 0;
        cycle_cnt   = 0;
        n_pass      = 0;
        n_fail      = 0;
        vec_errs    = 0;

        $readmemh("verification/pi_route_stimulus.txt", stim_mem);
        // The first unread id word is X and ends the list
        while ((n_vec < MAX_VEC) && !$isunknown(field_at(n_vec, 0))) begin
            n_vec++;
        end
        cycle_limit = n_vec + 20;

        repeat (2) @(posedge clk); // Turn register back to L_TURN
        #1;
        rst = 1'b0;

        // Vectors run back to back and the turn carries over between them
        for (int v = 0; v < n_vec; v++) begin
            @(posedge clk);
            #1;
            drive_vector(v);
            #8;              // Outputs settled just ahead of the next edge
            check_vector(v);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d", n_vec, n_pass, n_fail);
        if ((n_fail == 0) && (n_vec > 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            if (n_vec == 0) begin
                $display("No vectors were read from the stimulus file");
            end
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : pi_route_tb

// File: rtl/pi_route_top.sv
// Combinational routing with a single turn register; no handshake, valid and bp are levels
`timescale 1ns/10ps

module pi_route_top #(
    parameter int POSL = 0, // Tree level of this switch
    parameter int POSX = 0  // Horizontal position within the level
) (
    input  logic                   clk,
    input  logic                   rst,      // Synchronous, active high
    input  pi_route_pkg::port_in_t i_port,   // Head packets of the four inputs
    input  pi_route_pkg::dir_vec_t i_out_bp, // Back-pressure from downstream buffers
    output pi_route_pkg::dir_vec_t o_out_v,  // Output valid per channel
    output pi_route_pkg::dir_vec_t o_in_bp,  // Back-pressure to the input buffers
    output pi_route_pkg::sel_t     o_sel     // Output mux selects
);
    import pi_route_pkg::*;

    route_req_t wants; // Paths requested by valid channels
    route_req_t gets;  // Paths granted this cycle
    turn_e      turn;  // Direction holding priority

    // Address to requested paths
    pi_addr_decode #(
        .POSL (POSL),
        .POSX (POSX)
    ) u_addr_decode (
        .i_port  (i_port),
        .o_wants (wants)
    );

    // Refused inputs steer the next turn
    pi_turn_arbiter u_turn_arbiter (
        .clk     (clk),
        .rst     (rst),
        .i_in_bp (o_in_bp),
        .o_turn  (turn)
    );

    pi_vc_grant u_vc_grant (
        .i_wants  (wants),
        .i_turn   (turn),
        .i_out_bp (i_out_bp),
        .o_gets   (gets),
        .o_out_v  (o_out_v),
        .o_in_bp  (o_in_bp)
    );

    // Grants to binary mux selects
    pi_sel_encode u_sel_encode (
        .i_gets (gets),
        .o_sel  (o_sel)
    );

endmodule : pi_route_top

// File: rtl/pi_sel_encode.sv
// Grants into one output are one-hot by construction; an idle output selects 0
`timescale 1ns/10ps

module pi_sel_encode (
    input  pi_route_pkg::route_req_t i_gets, // Granted paths
    output pi_route_pkg::sel_t       o_sel   // Binary mux select per output
);
    import pi_cfg_pkg::*;
    import pi_route_pkg::*;

    // Each third or half of a select range belongs to one source direction
    logic [3*VC_W-1:0] l_onehot;  // {r, u0, u1}
    logic [3*VC_W-1:0] r_onehot;  // {l, u0, u1}
    logic [2*VC_W-1:0] u0_onehot; // {l, r}
    logic [2*VC_W-1:0] u1_onehot; // {l, r}

    // Index of the set bit, or 0 when none is set
    // Narrower up vectors are zero-extended on the way in
    function automatic int onehot_idx(input logic [3*VC_W-1:0] onehot);
        int idx;
        idx = 0;
        for (int b = 0; b < 3 * VC_W; b++) begin
            if (onehot[b]) begin
                idx = b;
            end
        end
        return idx;
    endfunction

    assign l_onehot  = {i_gets.r_l, i_gets.u0_l, i_gets.u1_l};
    assign r_onehot  = {i_gets.l_r, i_gets.u0_r, i_gets.u1_r};
    // Right never reaches up0, left never reaches up1, so those slots stay empty
    assign u0_onehot = {i_gets.l_u0, vc_vec_t'(0)};
    assign u1_onehot = {vc_vec_t'(0), i_gets.r_u1};

    assign o_sel.l_sel  = lr_sel_t'(onehot_idx(l_onehot));
    assign o_sel.r_sel  = lr_sel_t'(onehot_idx(r_onehot));
    assign o_sel.u0_sel = up_sel_t'(onehot_idx(u0_onehot));
    assign o_sel.u1_sel = up_sel_t'(onehot_idx(u1_onehot));

endmodule : pi_sel_encode

// File: rtl/pi_vc_grant.sv
// Static VC priority only; a lower channel always beats a higher one of the same source
`timescale 1ns/10ps

module pi_vc_grant (
    input  pi_route_pkg::route_req_t i_wants,  // Paths asked for by each channel
    input  pi_route_pkg::turn_e      i_turn,   // Direction holding priority
    input  pi_route_pkg::dir_vec_t   i_out_bp, // Downstream buffer full, per output channel
    output pi_route_pkg::route_req_t o_gets,   // Paths granted this cycle
    output pi_route_pkg::dir_vec_t   o_out_v,  // Output valid per channel
    output pi_route_pkg::dir_vec_t   o_in_bp   // Input channel refused this cycle
);
    import pi_cfg_pkg::*;
    import pi_route_pkg::*;

    // Lowest eligible channel of one source toward one output
    // A channel is eligible when it wants the path, its source won the output
    // and the matching output channel has room
    function automatic vc_vec_t pick_vc(
        input vc_vec_t want,
        input vc_vec_t bp,
        input logic    win
    );
        vc_vec_t req;
        vc_vec_t gnt;
        req = want & ~bp & {VC_W{win}};
        gnt = '0;
        for (int vc = 0; vc < VC_W; vc++) begin
            if (req[vc] && (gnt == '0)) begin
                gnt[vc] = 1'b1; // No lower channel took it
            end
        end
        return gnt;
    endfunction

    // Winning a direction is not a grant; it ignores whether the source wants it
    logic l_wins_r;
    logic u0_wins_r;
    logic u1_wins_r;
    logic r_wins_l;
    logic u0_wins_l;
    logic u1_wins_l;

    // Right output, contested by left, up0 and up1
    assign l_wins_r  = (i_turn == L_TURN)  | (~(|i_wants.u0_r) & ~(|i_wants.u1_r));
    assign u0_wins_r = (i_turn == U0_TURN) | (~(|i_wants.l_r)  & ~(|i_wants.u1_r));
    assign u1_wins_r = (i_turn == U1_TURN) | (~(|i_wants.l_r)  & ~(|i_wants.u0_r));

    // Left output, contested by right, up0 and up1
    assign r_wins_l  = (i_turn == R_TURN)  | (~(|i_wants.u0_l) & ~(|i_wants.u1_l));
    assign u0_wins_l = (i_turn == U0_TURN) | (~(|i_wants.r_l)  & ~(|i_wants.u1_l));
    assign u1_wins_l = (i_turn == U1_TURN) | (~(|i_wants.r_l)  & ~(|i_wants.u0_l));

    // Grants per path
    assign o_gets.l_r  = pick_vc(i_wants.l_r,  i_out_bp.r, l_wins_r);
    assign o_gets.u0_r = pick_vc(i_wants.u0_r, i_out_bp.r, u0_wins_r);
    assign o_gets.u1_r = pick_vc(i_wants.u1_r, i_out_bp.r, u1_wins_r);
    assign o_gets.r_l  = pick_vc(i_wants.r_l,  i_out_bp.l, r_wins_l);
    assign o_gets.u0_l = pick_vc(i_wants.u0_l, i_out_bp.l, u0_wins_l);
    assign o_gets.u1_l = pick_vc(i_wants.u1_l, i_out_bp.l, u1_wins_l);
    // Up0 is reached only from left and up1 only from right, no contest
    assign o_gets.l_u0 = pick_vc(i_wants.l_u0, i_out_bp.u0, 1'b1);
    assign o_gets.r_u1 = pick_vc(i_wants.r_u1, i_out_bp.u1, 1'b1);

    // Any grant into a direction makes that output channel valid
    assign o_out_v.l  = o_gets.r_l | o_gets.u0_l | o_gets.u1_l;
    assign o_out_v.r  = o_gets.l_r | o_gets.u0_r | o_gets.u1_r;
    assign o_out_v.u0 = o_gets.l_u0;
    assign o_out_v.u1 = o_gets.r_u1;

    // Head packet stays put when its path was refused
    assign o_in_bp.l  = (i_wants.l_r  & ~o_gets.l_r)  | (i_wants.l_u0 & ~o_gets.l_u0);
    assign o_in_bp.r  = (i_wants.r_l  & ~o_gets.r_l)  | (i_wants.r_u1 & ~o_gets.r_u1);
    assign o_in_bp.u0 = (i_wants.u0_l & ~o_gets.u0_l) | (i_wants.u0_r & ~o_gets.u0_r);
    assign o_in_bp.u1 = (i_wants.u1_l & ~o_gets.u1_l) | (i_wants.u1_r & ~o_gets.u1_r);

endmodule : pi_vc_grant

// File: rtl/pi_turn_arbiter.sv
// Turn moves only on back-pressure seen this cycle and takes effect one cycle later
`timescale 1ns/10ps

module pi_turn_arbiter (
    input  logic                   clk,
    input  logic                   rst,     // Synchronous, active high
    input  pi_route_pkg::dir_vec_t i_in_bp, // Input back-pressure of this cycle
    output pi_route_pkg::turn_e    o_turn   // Direction holding priority
);
    import pi_route_pkg::*;

    logic [3:0] waiting; // Bit index matches the turn_e encoding
    turn_e      next_turn;

    // A direction waits when any of its channels was refused
    assign waiting[L_TURN]  = |i_in_bp.l;
    assign waiting[R_TURN]  = |i_in_bp.r;
    assign waiting[U0_TURN] = |i_in_bp.u0;
    assign waiting[U1_TURN] = |i_in_bp.u1;

    // Next waiting direction in the order L, R, U0, U1, wrapping around
    // The current holder is checked last, so it keeps the turn only when alone
    always_comb begin
        logic [1:0] cand;
        next_turn = o_turn; // Nobody waiting, turn stays
        cand      = '0;
        // Walk from the farthest candidate down so the nearest one sticks
        for (int step = 3; step >= 1; step--) begin
            cand = 2'(o_turn + step);
            if (waiting[cand]) begin
                next_turn = turn_e'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_turn <= L_TURN;   // Left starts with priority
        end else begin
            o_turn <= next_turn;
        end
    end

endmodule : pi_turn_arbiter

// File: rtl/pi_addr_decode.sv
// Deterministic up routing only; POSX must fit in the address bits above POSL
`timescale 1ns/10ps

module pi_addr_decode #(
    parameter int POSL = 0, // Tree level of this switch
    parameter int POSX = 0  // Horizontal position within that level
) (
    input  pi_route_pkg::port_in_t   i_port,  // Valid and address per port and channel
    output pi_route_pkg::route_req_t o_wants  // Paths each channel asks for
);
    import pi_cfg_pkg::*;
    import pi_route_pkg::*;

    // Destination lies below this switch when the bits above POSL equal POSX
    vc_vec_t l_home;
    vc_vec_t r_home;

    always_comb begin
        for (int vc = 0; vc < VC_W; vc++) begin
            l_home[vc] = (i_port.l.addr[vc] >> (POSL + 1)) == addr_t'(POSX);
            r_home[vc] = (i_port.r.addr[vc] >> (POSL + 1)) == addr_t'(POSX);
        end
    end

    // Bit POSL of the address picks the side, 0 is left and 1 is right
    always_comb begin
        for (int vc = 0; vc < VC_W; vc++) begin
            // Left input turns right inside the subtree, else climbs on up0
            o_wants.l_r[vc]  = i_port.l.v[vc] & i_port.l.addr[vc][POSL] & l_home[vc];
            o_wants.l_u0[vc] = i_port.l.v[vc] & ~l_home[vc];

            // Right input mirrors left, climbing on up1
            o_wants.r_l[vc]  = i_port.r.v[vc] & ~i_port.r.addr[vc][POSL] & r_home[vc];
            o_wants.r_u1[vc] = i_port.r.v[vc] & ~r_home[vc];

            // Traffic from above always goes down
            o_wants.u0_l[vc] = i_port.u0.v[vc] & ~i_port.u0.addr[vc][POSL];
            o_wants.u0_r[vc] = i_port.u0.v[vc] &  i_port.u0.addr[vc][POSL];
            o_wants.u1_l[vc] = i_port.u1.v[vc] & ~i_port.u1.addr[vc][POSL];
            o_wants.u1_r[vc] = i_port.u1.v[vc] &  i_port.u1.addr[vc][POSL];
        end
    end

    // A self-loop address (left to left, right to right) matches no path
    // and is silently dropped here

endmodule : pi_addr_decode

// File: rtl/pi_route_pkg.sv
// Port and request layouts of the Pi switch; only legal non-generalized paths exist
package pi_route_pkg;

    // Plain vectors with a meaning
    typedef logic [pi_cfg_pkg::ADDR_W-1:0]   addr_t;   // Destination client address
    typedef logic [pi_cfg_pkg::VC_W-1:0]     vc_vec_t; // One bit per virtual channel
    typedef logic [pi_cfg_pkg::LR_SEL_W-1:0] lr_sel_t; // Left and right mux select
    typedef logic [pi_cfg_pkg::UP_SEL_W-1:0] up_sel_t; // Up mux select

    // Whose turn it is in the direction round robin
    typedef enum logic [1:0] {
        L_TURN  = 2'd0,
        R_TURN  = 2'd1,
        U0_TURN = 2'd2,
        U1_TURN = 2'd3
    } turn_e;

    // Head of one input port, per channel
    typedef struct packed {
        vc_vec_t                             v;    // Channel holds a packet
        addr_t [pi_cfg_pkg::VC_W-1:0]        addr; // Destination, qualified by v
    } in_port_t;

    // All four input ports
    typedef struct packed {
        in_port_t l;
        in_port_t r;
        in_port_t u0;
        in_port_t u1;
    } port_in_t;

    // Per-direction channel vector, used for valids and back-pressure
    typedef struct packed {
        vc_vec_t l;
        vc_vec_t r;
        vc_vec_t u0;
        vc_vec_t u1;
    } dir_vec_t;

    // One field per legal source_destination path
    // Left never goes to up1 and right never to up0
    typedef struct packed {
        vc_vec_t l_r;
        vc_vec_t l_u0;
        vc_vec_t r_l;
        vc_vec_t r_u1;
        vc_vec_t u0_l;
        vc_vec_t u0_r;
        vc_vec_t u1_l;
        vc_vec_t u1_r;
    } route_req_t;

    // Output mux selects
    typedef struct packed {
        lr_sel_t l_sel;
        lr_sel_t r_sel;
        up_sel_t u0_sel;
        up_sel_t u1_sel;
    } sel_t;

endpackage : pi_route_pkg

// File: rtl/pi_cfg_pkg.sv
// Sizes are fixed for an 8-client tree with 2 VCs per port; select widths follow VC_W
package pi_cfg_pkg;

    // Network size
    localparam int N_CLIENTS = 8;                     // Leaf clients in the fat tree
    localparam int ADDR_W    = $clog2(N_CLIENTS) + 1; // Client index plus one level bit

    // Virtual channels per port
    // Lower channels win over higher ones inside a source direction,
    // so VC0 is meant for replies and VC1 for requests
    localparam int VC_W = 2;

    // Mux select widths
    // Left and right outputs are fed by three source directions
    localparam int LR_SEL_W = $clog2(VC_W * 3);
    // Up outputs are fed by left and right only
    localparam int UP_SEL_W = $clog2(VC_W * 2);

endpackage : pi_cfg_pkg
